// File: Makefile
# Verilator build and run for the AXI4 memory slave testbench

VERILATOR  ?= verilator
TOP        ?= axi_mem_tb
FILELIST   ?= filelist.f
OBJ_DIR    ?= obj_dir
LOG        ?= sim.log
VFLAGS     ?= --binary --timing
EXTRA      ?=

SIM_BIN    := $(OBJ_DIR)/V$(TOP)

SRCS := src/axi_mem_pkg.sv \
        src/axi_mem_burst_ctrl.sv \
        src/axi_mem_beat_addr.sv \
        src/axi_mem_array.sv \
        src/axi_mem_slave.sv \
        verif/axi_mem_tb.sv \
        verif/axi_mem_tb_drv.svh

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# rebuilt only when a source or the file list changes
$(SIM_BIN): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) $(EXTRA) -f $(FILELIST) \
		--top-module $(TOP) --Mdir $(OBJ_DIR) -o V$(TOP)

$(LOG): $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true

run: $(SIM_BIN)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "CHECKS FAILED" $(LOG); then \
		echo "simulation failed, see $(LOG)"; exit 1; \
	fi
	@if ! grep -q "ALL CHECKS PASSED" $(LOG); then \
		echo "simulation ended without a result, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// File: filelist.f
+incdir+verif
src/axi_mem_pkg.sv
src/axi_mem_burst_ctrl.sv
src/axi_mem_beat_addr.sv
src/axi_mem_array.sv
src/axi_mem_slave.sv
verif/axi_mem_tb.sv

// File: src/axi_mem_array.sv
//----------------------------------------------------------------------------
// storage array for the AXI4 memory slave
//   64 words of 64 bits with a written flag per word
//   byte-merged write, unwritten words read as all ones
//   combinational read port on the same index
//----------------------------------------------------------------------------

`default_nettype none

module axi_mem_array
   import axi_mem_pkg::*;
(
   input  wire                 clk_core,
   input  wire                 rst_n,
   input  wire                 we,
   input  wire [word_aw-1:0]   idx,
   input  wire [strb_w-1:0]    strb,
   input  wire [strb_w-1:0]    lanes,   // lanes legal for this beat
   input  wire [data_w-1:0]    wdata,
   output logic [data_w-1:0]   rdata
);

   logic [data_w-1:0]    mem [mem_words];
   logic [mem_words-1:0] written_q;
   logic [strb_w-1:0]    byte_en;
   logic [data_w-1:0]    merged;

   //------------------------------------------------------------------------
   // read
   //------------------------------------------------------------------------
   // never-written words give the default all-ones pattern
   assign rdata = written_q[idx] ? mem[idx] : '1;

   //------------------------------------------------------------------------
   // write
   //------------------------------------------------------------------------
   assign byte_en = strb & lanes;

   always_comb begin
      merged = rdata;   // old word, or all ones
      for (int i = 0; i < strb_w; i++) begin
         if (byte_en[i])
            merged[8*i +: 8] = wdata[8*i +: 8];
      end
   end

   always_ff @(posedge clk_core) begin
      if (we)
         mem[idx] <= merged;
   end

   always_ff @(posedge clk_core or negedge rst_n) begin
      if (!rst_n)
         written_q <= '0;
      else if (we)
         written_q[idx] <= 1'b1;   // set even with no lanes enabled
   end

endmodule

`default_nettype wire

// File: src/axi_mem_beat_addr.sv
//----------------------------------------------------------------------------
// beat address generator
//   beat address register and remaining-beat counter
//   next address for INCR and WRAP bursts
//   window range check and byte lanes of a narrow beat
//----------------------------------------------------------------------------

`default_nettype none

module axi_mem_beat_addr
   import axi_mem_pkg::*;
(
   input  wire                 clk_core,
   input  wire                 rst_n,
   input  wire                 load,
   input  wire axi_cmd_t       cmd,
   input  wire                 adv,
   output logic [word_aw-1:0]  word_idx,
   output logic [strb_w-1:0]   byte_lanes,
   output logic                in_range,
   output logic                last_beat
);

   logic [addr_w-1:0] addr_q;
   logic [addr_w-1:0] mask_q;     // wrap mask, all ones for incr
   logic [1:0]        size_q;     // clamped to the bus width
   logic [7:0]        cnt_q;      // beats left after this one
   logic [1:0]        size_in;
   logic [addr_w-1:0] step;
   logic [addr_w-1:0] aligned;
   logic [addr_w-1:0] next_addr;
   logic [3:0]        lane_lo;
   logic [3:0]        lane_hi;

   assign size_in = (cmd.size > 3'd3) ? 2'd3 : cmd.size[1:0];

   //------------------------------------------------------------------------
   // next address
   //------------------------------------------------------------------------
   assign step      = addr_w'(1) << size_q;
   assign aligned   = addr_q & ~(step - addr_w'(1));
   // upper bits stay inside the wrap block, lower bits step on
   assign next_addr = (addr_q & ~mask_q) | ((aligned + step) & mask_q);

   always_ff @(posedge clk_core or negedge rst_n) begin
      if (!rst_n) begin
         addr_q <= '0;
         mask_q <= '1;
         size_q <= '0;
         cnt_q  <= '0;
      end else if (load) begin
         addr_q <= cmd.addr;
         size_q <= size_in;
         cnt_q  <= cmd.len;
         if (cmd.burst == burst_wrap)
            mask_q <= ((addr_w'(cmd.len) + addr_w'(1)) << size_in) - addr_w'(1);
         else
            mask_q <= '1;
      end else if (adv) begin
         addr_q <= next_addr;
         cnt_q  <= cnt_q - 8'd1;
      end
   end

   //------------------------------------------------------------------------
   // beat outputs
   //------------------------------------------------------------------------
   assign word_idx  = addr_q[$clog2(strb_w) +: word_aw];
   assign in_range  = (addr_q < addr_w'(mem_bytes));
   assign last_beat = (cnt_q == 8'd0);

   // lanes from the beat address to the top of its size container
   assign lane_lo = {1'b0, addr_q[2:0]};
   assign lane_hi = {1'b0, aligned[2:0]} + 4'(step) - 4'd1;

   always_comb begin
      for (int i = 0; i < strb_w; i++)
         byte_lanes[i] = (4'(i) >= lane_lo) && (4'(i) <= lane_hi);
   end

endmodule

`default_nettype wire

// File: src/axi_mem_burst_ctrl.sv
//----------------------------------------------------------------------------
// burst controller for the AXI4 memory slave
//   idle / write data / write response / read data FSM
//   alternating grant between AW and AR in idle
//   latched transaction ID, sticky SLVERR across a write burst
//   channel ready/valid controls and beat strobes to the datapath
//----------------------------------------------------------------------------

`default_nettype none

module axi_mem_burst_ctrl
   import axi_mem_pkg::*;
(
   input  wire              clk_core,
   input  wire              rst_n,

   // address channels
   input  wire              aw_valid,
   input  wire axi_cmd_t    aw_cmd,
   output logic             aw_ready,
   input  wire              ar_valid,
   input  wire axi_cmd_t    ar_cmd,
   output logic             ar_ready,

   // data and response channel controls
   input  wire              w_valid,
   input  wire              w_last,
   output logic             w_ready,
   output logic             b_valid,
   input  wire              b_ready,
   output axi_bresp_t       b_resp,
   output logic             r_valid,
   input  wire              r_ready,
   output logic [1:0]       r_resp,
   output logic [id_w-1:0]  r_id,

   // beat address generator
   output logic             cmd_load,
   output axi_cmd_t         cmd,
   output logic             beat_adv,
   input  wire              in_range,
   input  wire              last_beat,

   output logic             mem_we
);

   typedef enum logic [1:0] {
      st_idle,
      st_wdata,
      st_wresp,
      st_rdata
   } state_t;

   state_t          state_q;
   state_t          state_d;
   logic            wr_pref_q;     // write side wins the next tie
   logic            err_q;         // an out-of-range beat was dropped
   logic [id_w-1:0] id_q;
   logic            sel_wr;
   logic            aw_xfer;
   logic            ar_xfer;
   logic            w_xfer;
   logic            b_xfer;
   logic            r_xfer;

   //------------------------------------------------------------------------
   // grant and handshakes
   //------------------------------------------------------------------------
   assign sel_wr   = aw_valid && (!ar_valid || wr_pref_q);

   assign aw_ready = (state_q == st_idle) && sel_wr;
   assign ar_ready = (state_q == st_idle) && ar_valid && !sel_wr;
   assign w_ready  = (state_q == st_wdata);
   assign b_valid  = (state_q == st_wresp);
   assign r_valid  = (state_q == st_rdata);

   assign aw_xfer  = aw_valid && aw_ready;
   assign ar_xfer  = ar_valid && ar_ready;
   assign w_xfer   = w_valid && w_ready;
   assign b_xfer   = b_valid && b_ready;
   assign r_xfer   = r_valid && r_ready;

   // command goes to the address generator on the accept edge
   assign cmd      = sel_wr ? aw_cmd : ar_cmd;
   assign cmd_load = aw_xfer || ar_xfer;
   assign beat_adv = w_xfer || r_xfer;
   assign mem_we   = w_xfer && in_range;   // dropped beats never reach the array

   //------------------------------------------------------------------------
   // FSM
   //------------------------------------------------------------------------
   always_comb begin
      state_d = state_q;
      case (state_q)
         st_idle: begin
            if (aw_xfer)
               state_d = st_wdata;
            else if (ar_xfer)
               state_d = st_rdata;
         end
         st_wdata: if (w_xfer && w_last) state_d = st_wresp;   // w last ends the burst
         st_wresp: if (b_xfer) state_d = st_idle;
         st_rdata: if (r_xfer && last_beat) state_d = st_idle;
         default:  state_d = st_idle;
      endcase
   end

   always_ff @(posedge clk_core or negedge rst_n) begin
      if (!rst_n) begin
         state_q   <= st_idle;
         wr_pref_q <= 1'b1;
         err_q     <= 1'b0;
      end else begin
         state_q <= state_d;
         if (aw_xfer)
            wr_pref_q <= 1'b0;
         else if (ar_xfer)
            wr_pref_q <= 1'b1;
         if (cmd_load)
            err_q <= 1'b0;
         else if (w_xfer && !in_range)
            err_q <= 1'b1;
      end
   end

   always_ff @(posedge clk_core) begin
      if (cmd_load)
         id_q <= cmd.id;
   end

   //------------------------------------------------------------------------
   // responses
   //------------------------------------------------------------------------
   assign b_resp = '{id: id_q, resp: (err_q ? resp_slverr : resp_okay)};
   assign r_id   = id_q;
   assign r_resp = in_range ? resp_okay : resp_slverr;   // per beat

endmodule

`default_nettype wire

// File: src/axi_mem_pkg.sv
//----------------------------------------------------------------------------
// shared definitions for the AXI4 memory slave
//   bus and memory sizing constants
//   response and burst codes
//   channel payload structs for AW/AR, W, R and B
//----------------------------------------------------------------------------

`default_nettype none

package axi_mem_pkg;

   //------------------------------------------------------------------------
   // sizing
   //------------------------------------------------------------------------
   localparam int data_w    = 64;   // bus data width
   localparam int strb_w    = 8;    // byte lanes per beat
   localparam int addr_w    = 16;
   localparam int id_w      = 4;

   localparam int mem_words = 64;   // array depth
   localparam int mem_bytes = 512;  // window size, mem_words * strb_w
   localparam int word_aw   = 6;    // array index width

   //------------------------------------------------------------------------
   // protocol codes
   //------------------------------------------------------------------------
   localparam logic [1:0] resp_okay   = 2'b00;
   localparam logic [1:0] resp_slverr = 2'b10;

   // fixed (2'b00) and reserved codes fall back to incr
   localparam logic [1:0] burst_incr  = 2'b01;
   localparam logic [1:0] burst_wrap  = 2'b10;

   //------------------------------------------------------------------------
   // channel payloads
   //------------------------------------------------------------------------

   // AW or AR command
   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [addr_w-1:0] addr;
      logic [7:0]        len;     // beats minus one
      logic [2:0]        size;    // log2 of bytes per beat
      logic [1:0]        burst;
   } axi_cmd_t;

   typedef struct packed {
      logic [data_w-1:0] data;
      logic [strb_w-1:0] strb;
      logic              last;
   } axi_wbeat_t;

   typedef struct packed {
      logic [id_w-1:0]   id;
      logic [data_w-1:0] data;
      logic [1:0]        resp;
      logic              last;
   } axi_rbeat_t;

   typedef struct packed {
      logic [id_w-1:0] id;
      logic [1:0]      resp;
   } axi_bresp_t;

endpackage

`default_nettype wire

// File: src/axi_mem_slave.sv
//----------------------------------------------------------------------------
// AXI4 memory slave, top level
//   AW, W, B, AR and R channel ports
//   burst controller, beat address generator and storage array
//   R beat assembly from array data and controller tags
//----------------------------------------------------------------------------

`default_nettype none

module axi_mem_slave
   import axi_mem_pkg::*;
(
   input  wire              clk_core,
   input  wire              rst_n,

   input  wire axi_cmd_t    aw_cmd,
   input  wire              aw_valid,
   output logic             aw_ready,

   input  wire axi_wbeat_t  w_beat,
   input  wire              w_valid,
   output logic             w_ready,

   output axi_bresp_t       b_resp,
   output logic             b_valid,
   input  wire              b_ready,

   input  wire axi_cmd_t    ar_cmd,
   input  wire              ar_valid,
   output logic             ar_ready,

   output axi_rbeat_t       r_beat,
   output logic             r_valid,
   input  wire              r_ready
);

   axi_cmd_t            cmd;
   logic                cmd_load;
   logic                beat_adv;
   logic                mem_we;
   logic                in_range;
   logic                last_beat;
   logic [word_aw-1:0]  word_idx;
   logic [strb_w-1:0]   byte_lanes;
   logic [data_w-1:0]   rdata;
   logic [1:0]          r_resp;
   logic [id_w-1:0]     r_id;

   //------------------------------------------------------------------------
   // instances
   //------------------------------------------------------------------------
   axi_mem_burst_ctrl u_ctrl (
      .clk_core (clk_core),   .rst_n     (rst_n),
      .aw_valid (aw_valid),   .aw_cmd    (aw_cmd),     .aw_ready (aw_ready),
      .ar_valid (ar_valid),   .ar_cmd    (ar_cmd),     .ar_ready (ar_ready),
      .w_valid  (w_valid),    .w_last    (w_beat.last), .w_ready (w_ready),
      .b_valid  (b_valid),    .b_ready   (b_ready),    .b_resp   (b_resp),
      .r_valid  (r_valid),    .r_ready   (r_ready),
      .r_resp   (r_resp),     .r_id      (r_id),
      .cmd_load (cmd_load),   .cmd       (cmd),        .beat_adv (beat_adv),
      .in_range (in_range),   .last_beat (last_beat),  .mem_we   (mem_we)
   );

   axi_mem_beat_addr u_addr (
      .clk_core (clk_core),   .rst_n      (rst_n),
      .load     (cmd_load),   .cmd        (cmd),        .adv      (beat_adv),
      .word_idx (word_idx),   .byte_lanes (byte_lanes),
      .in_range (in_range),   .last_beat  (last_beat)
   );

   axi_mem_array u_mem (
      .clk_core (clk_core),   .rst_n (rst_n),
      .we       (mem_we),     .idx   (word_idx),
      .strb     (w_beat.strb), .lanes (byte_lanes),
      .wdata    (w_beat.data), .rdata (rdata)
   );

   // beats past the window read as all ones
   assign r_beat = '{id:   r_id,
                     data: (in_range ? rdata : '1),
                     resp: r_resp,
                     last: last_beat};

endmodule

`default_nettype wire

// File: verif/axi_mem_tb_drv.svh
//----------------------------------------------------------------------------
// testbench channel tasks
//   LFSR bit source for data, strobes, gaps and back-pressure
//   AW, AR and W drivers, B and R collectors with timeouts
//   write and read burst sequences checked against the model
//----------------------------------------------------------------------------

`ifndef AXI_MEM_TB_DRV_SVH
`define AXI_MEM_TB_DRV_SVH

// Fibonacci LFSR with taps 32 22 2 1 stepped once per bit
function automatic logic [63:0] rand_bits(int n);
   logic [63:0] v;
   logic        fb;
   v = '0;
   for (int i = 0; i < n; i++) begin
      fb     = lfsr_q[31] ^ lfsr_q[21] ^ lfsr_q[1] ^ lfsr_q[0];
      lfsr_q = {lfsr_q[30:0], fb};
      v      = {v[62:0], fb};
   end
   return v;
endfunction

task automatic note_timeout(string what);
   $display("timeout: no handshake on %s within %0d cycles", what, wait_limit);
   timed_out = 1'b1;
   errors++;
endtask

task automatic send_aw(axi_cmd_t c);
   int n;
   n        = 0;
   aw_cmd   = c;
   aw_valid = 1'b1;
   do begin
      @(negedge clk_core);
      n++;
   end while (!aw_ready && n < wait_limit);
   if (!aw_ready)
      note_timeout("AW");
   @(posedge clk_core);
   #2 aw_valid = 1'b0;
endtask

task automatic send_ar(axi_cmd_t c);
   int n;
   n        = 0;
   ar_cmd   = c;
   ar_valid = 1'b1;
   do begin
      @(negedge clk_core);
      n++;
   end while (!ar_ready && n < wait_limit);
   if (!ar_ready)
      note_timeout("AR");
   @(posedge clk_core);
   #2 ar_valid = 1'b0;
endtask

task automatic send_w();
   int n;
   foreach (wdata_q[k]) begin
      repeat (int'(rand_bits(2))) begin   // idle gap before the beat
         @(posedge clk_core);
         #2;
      end
      w_beat  = '{data: wdata_q[k], strb: wstrb_q[k], last: (k == wdata_q.size() - 1)};
      w_valid = 1'b1;
      n       = 0;
      do begin
         @(negedge clk_core);
         n++;
      end while (!w_ready && n < wait_limit);
      if (!w_ready)
         note_timeout("W");
      @(posedge clk_core);
      #2 w_valid = 1'b0;
   end
endtask

task automatic collect_b(output axi_bresp_t br);
   int   n;
   logic hit;
   n   = 0;
   hit = 1'b0;
   br  = '0;
   while (!hit && n < wait_limit) begin
      b_ready = (rand_bits(2) != 0);   // low about a quarter of the time
      @(negedge clk_core);
      hit = b_valid && b_ready;
      br  = b_resp;
      n++;
      @(posedge clk_core);
      #2;
   end
   b_ready = 1'b0;
   if (!hit)
      note_timeout("B");
endtask

task automatic collect_r(int beats);
   int n;
   n = 0;
   rbeat_q.delete();
   while (rbeat_q.size() < beats && n < wait_limit * beats) begin
      r_ready = (rand_bits(2) != 0);
      @(negedge clk_core);
      if (r_valid && r_ready)
         rbeat_q.push_back(r_beat);
      n++;
      @(posedge clk_core);
      #2;
   end
   r_ready = 1'b0;
   if (rbeat_q.size() < beats)
      note_timeout("R");
endtask

//----------------------------------------------------------------------------
// burst sequences
//----------------------------------------------------------------------------
task automatic do_write(string name, axi_cmd_t c, logic rand_strb, logic [1:0] exp_resp);
   axi_bresp_t br;
   wdata_q.delete();
   wstrb_q.delete();
   for (int k = 0; k <= int'(c.len); k++) begin
      wdata_q.push_back(rand_bits(64));
      wstrb_q.push_back(rand_strb ? 8'(rand_bits(8)) : 8'hff);
      ref_write(c, k, wdata_q[k], wstrb_q[k]);
   end
   send_aw(c);
   send_w();
   collect_b(br);
   checks++;
   if (br.id != c.id || br.resp != exp_resp) begin
      $display("** Error %s B: expected id %h resp %h actual id %h resp %h",
               name, c.id, exp_resp, br.id, br.resp);
      errors++;
   end
endtask

task automatic do_read(string name, axi_cmd_t c, logic [1:0] burst_exp);
   int          a;
   logic [63:0] exp_data;
   logic [1:0]  exp_resp;
   logic [1:0]  worst;
   worst = resp_okay;
   send_ar(c);
   collect_r(int'(c.len) + 1);
   foreach (rbeat_q[k]) begin
      a        = beat_addr(c, k);
      exp_data = ref_word(a);
      exp_resp = (a < mem_bytes) ? resp_okay : resp_slverr;
      checks++;
      if (rbeat_q[k].data != exp_data) begin
         $display("** Error %s beat %0d data: expected %h actual %h",
                  name, k, exp_data, rbeat_q[k].data);
         errors++;
      end
      if (rbeat_q[k].resp != exp_resp || rbeat_q[k].id != c.id) begin
         $display("** Error %s beat %0d id/resp: expected %h/%h actual %h/%h",
                  name, k, c.id, exp_resp, rbeat_q[k].id, rbeat_q[k].resp);
         errors++;
      end
      if (rbeat_q[k].last != (k == int'(c.len))) begin
         $display("** Error %s beat %0d last: expected %b actual %b",
                  name, k, (k == int'(c.len)), rbeat_q[k].last);
         errors++;
      end
      if (rbeat_q[k].resp == resp_slverr)
         worst = resp_slverr;
   end
   checks++;
   if (worst != burst_exp) begin
      $display("** Error %s burst resp: expected %h actual %h", name, burst_exp, worst);
      errors++;
   end
endtask

`endif

// File: verif/axi_mem_tb.sv
//----------------------------------------------------------------------------
// testbench for the AXI4 memory slave
//   clock, reset and DUT instance
//   burst table applied in a loop, reference byte model
//   concurrent AW/AR arbitration burst and result report
//----------------------------------------------------------------------------

`default_nettype none

module axi_mem_tb
   import axi_mem_pkg::*;
;
   timeunit 1ns;
   timeprecision 100ps;

   localparam int wait_limit = 200;   // cycles per handshake

   typedef struct packed {
      logic       wr;
      logic       rand_strb;
      logic [1:0] resp;
      axi_cmd_t   cmd;
   } row_t;

   logic       clk_core;
   logic       rst_n;
   axi_cmd_t   aw_cmd;
   logic       aw_valid;
   logic       aw_ready;
   axi_wbeat_t w_beat;
   logic       w_valid;
   logic       w_ready;
   axi_bresp_t b_resp;
   logic       b_valid;
   logic       b_ready;
   axi_cmd_t   ar_cmd;
   logic       ar_valid;
   logic       ar_ready;
   axi_rbeat_t r_beat;
   logic       r_valid;
   logic       r_ready;

   logic [31:0] lfsr_q = 32'h5479_06ad;
   logic [7:0]  ref_mem [mem_bytes];     // reference bytes start at 0xff
   logic [63:0] wdata_q [$];
   logic [7:0]  wstrb_q [$];
   axi_rbeat_t  rbeat_q [$];
   string       row_name [$];
   row_t        row_q [$];
   int          errors = 0;
   int          checks = 0;
   logic        timed_out = 1'b0;

   axi_mem_slave u_axi_mem_slave (
      .clk_core (clk_core), .rst_n    (rst_n),
      .aw_cmd   (aw_cmd),   .aw_valid (aw_valid), .aw_ready (aw_ready),
      .w_beat   (w_beat),   .w_valid  (w_valid),  .w_ready  (w_ready),
      .b_resp   (b_resp),   .b_valid  (b_valid),  .b_ready  (b_ready),
      .ar_cmd   (ar_cmd),   .ar_valid (ar_valid), .ar_ready (ar_ready),
      .r_beat   (r_beat),   .r_valid  (r_valid),  .r_ready  (r_ready)
   );

   `include "axi_mem_tb_drv.svh"

   initial begin
      clk_core = 1'b0;
      forever #10 clk_core = ~clk_core;
   end

   //------------------------------------------------------------------------
   // reference model
   //------------------------------------------------------------------------
   // address of beat k by the AXI INCR and WRAP rules
   function automatic int beat_addr(axi_cmd_t c, int k);
      int nb;
      int al;
      int blk;
      int base;
      nb = 1 << c.size;
      al = int'(c.addr) & ~(nb - 1);
      if (k == 0)
         return int'(c.addr);
      if (c.burst == burst_wrap) begin
         blk  = (int'(c.len) + 1) * nb;
         base = al - (al % blk);
         return base + ((al - base) + k * nb) % blk;
      end
      return al + k * nb;
   endfunction

   function automatic void ref_write(axi_cmd_t c, int k, logic [63:0] d, logic [7:0] s);
      int a;
      int nb;
      int lo;
      int hi;
      a  = beat_addr(c, k);
      nb = 1 << c.size;
      lo = a % 8;
      hi = (a & ~(nb - 1)) % 8 + nb - 1;
      if (a >= mem_bytes)
         return;   // beat dropped
      for (int i = lo; i <= hi; i++) begin
         if (s[i])
            ref_mem[(a & ~7) + i] = d[8*i +: 8];
      end
   endfunction

   function automatic logic [63:0] ref_word(int a);
      logic [63:0] w;
      w = '1;
      if (a < mem_bytes) begin
         for (int i = 0; i < 8; i++)
            w[8*i +: 8] = ref_mem[(a & ~7) + i];
      end
      return w;
   endfunction

   //------------------------------------------------------------------------
   // burst table
   //------------------------------------------------------------------------
   task automatic add_row(string n, logic wr, logic [15:0] a, logic [7:0] len,
                          logic [2:0] sz, logic [1:0] bu, logic rs, logic [1:0] rsp);
      row_t r;
      r.wr        = wr;
      r.rand_strb = rs;
      r.resp      = rsp;
      r.cmd       = '{id: 4'(row_q.size()), addr: a, len: len, size: sz, burst: bu};
      row_name.push_back(n);
      row_q.push_back(r);
   endtask

   task automatic build_table();
      add_row("rd_unwritten", 0, 16'h000, 8'd3,  3'd3, burst_incr, 0, resp_okay);
      add_row("wr_incr_1",    1, 16'h000, 8'd0,  3'd3, burst_incr, 0, resp_okay);
      add_row("wr_incr_4",    1, 16'h040, 8'd3,  3'd3, burst_incr, 0, resp_okay);
      add_row("wr_incr_16",   1, 16'h080, 8'd15, 3'd3, burst_incr, 0, resp_okay);
      add_row("rd_incr_32",   0, 16'h000, 8'd31, 3'd3, burst_incr, 0, resp_okay);
      add_row("wr_strb_rand", 1, 16'h040, 8'd3,  3'd3, burst_incr, 1, resp_okay);
      add_row("wr_size1",     1, 16'h103, 8'd5,  3'd0, burst_incr, 0, resp_okay);
      add_row("wr_size2",     1, 16'h112, 8'd3,  3'd1, burst_incr, 1, resp_okay);
      add_row("wr_size4",     1, 16'h046, 8'd3,  3'd2, burst_incr, 0, resp_okay);
      add_row("rd_narrow",    0, 16'h040, 8'd31, 3'd3, burst_incr, 0, resp_okay);
      add_row("wr_wrap4",     1, 16'h168, 8'd3,  3'd3, burst_wrap, 0, resp_okay);
      add_row("wr_wrap8",     1, 16'h1a4, 8'd7,  3'd2, burst_wrap, 1, resp_okay);
      add_row("rd_wrap",      0, 16'h170, 8'd3,  3'd3, burst_wrap, 0, resp_okay);
      add_row("wr_oor",       1, 16'h1f0, 8'd3,  3'd3, burst_incr, 0, resp_slverr);
      add_row("rd_oor",       0, 16'h1e8, 8'd3,  3'd3, burst_incr, 0, resp_slverr);
      add_row("rd_all",       0, 16'h000, 8'd63, 3'd3, burst_incr, 0, resp_okay);
   endtask

   //------------------------------------------------------------------------
   // main sequence
   //------------------------------------------------------------------------
   initial begin
      axi_cmd_t wc;
      axi_cmd_t rc;
      rst_n    = 1'b0;
      aw_cmd   = '0;
      aw_valid = 1'b0;
      w_beat   = '0;
      w_valid  = 1'b0;
      b_ready  = 1'b0;
      ar_cmd   = '0;
      ar_valid = 1'b0;
      r_ready  = 1'b0;
      for (int i = 0; i < mem_bytes; i++)
         ref_mem[i] = 8'hff;
      build_table();

      repeat (10) @(posedge clk_core);
      #2 rst_n = 1'b1;

      // quiet outputs after reset
      repeat (3) begin
         @(negedge clk_core);
         checks++;
         if (b_valid || r_valid || aw_ready || ar_ready || w_ready) begin
            $display("** Error reset_state: expected 0 actual b%b r%b aw%b ar%b w%b",
                     b_valid, r_valid, aw_ready, ar_ready, w_ready);
            errors++;
         end
      end
      @(posedge clk_core);
      #2;

      foreach (row_q[i]) begin
         if (!timed_out) begin
            if (row_q[i].wr)
               do_write(row_name[i], row_q[i].cmd, row_q[i].rand_strb, row_q[i].resp);
            else
               do_read(row_name[i], row_q[i].cmd, row_q[i].resp);
         end
      end

      // AW and AR offered in the same cycle on disjoint regions
      wc = '{id: 4'ha, addr: 16'h1c0, len: 8'd3, size: 3'd3, burst: burst_incr};
      rc = '{id: 4'h5, addr: 16'h080, len: 8'd7, size: 3'd3, burst: burst_incr};
      if (!timed_out) begin
         fork
            do_write("arb_write", wc, 1'b0, resp_okay);
            do_read("arb_read", rc, resp_okay);
         join
      end
      rc = '{id: 4'h6, addr: 16'h1c0, len: 8'd3, size: 3'd3, burst: burst_incr};
      if (!timed_out)
         do_read("arb_readback", rc, resp_okay);

      $display("errors: %0d  checks: %0d", errors, checks);
      if (errors == 0 && !timed_out)
         $display("ALL CHECKS PASSED");
      else
         $display("CHECKS FAILED");
      $finish;
   end

endmodule

`default_nettype wire
